// ==== design/icache_params.svh ====
/*
  sizes of the 2-way instruction cache
  the two byte-offset bits are assumed zero and never looked at
*/
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

`define ICACHE_ADDR_W      32   // byte address of a fetch
`define ICACHE_SETS_LOG2   4    // 16 sets
`define ICACHE_WORDS_LOG2  2    // 4 words per line
`define ICACHE_WORD_W      32
`define ICACHE_BYTE_OFF_W  2

// derived widths
`define ICACHE_LINE_W      (`ICACHE_WORD_W << `ICACHE_WORDS_LOG2)
`define ICACHE_LINE_ADDR_W (`ICACHE_ADDR_W - `ICACHE_WORDS_LOG2 - `ICACHE_BYTE_OFF_W)
`define ICACHE_TAG_W       (`ICACHE_LINE_ADDR_W - `ICACHE_SETS_LOG2)

`endif

// ==== design/icache_pkg.sv ====
/*
  types shared by the cache blocks and the fetch/memory ports
  word 0 of a line sits in the low bits
*/
`include "icache_params.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0]      addr_t;
    typedef logic [`ICACHE_WORD_W-1:0]      word_t;
    typedef logic [`ICACHE_LINE_W-1:0]      line_t;
    typedef logic [`ICACHE_TAG_W-1:0]       tag_t;       // addr[31:8]
    typedef logic [`ICACHE_SETS_LOG2-1:0]   index_t;     // addr[7:4]
    typedef logic [`ICACHE_LINE_ADDR_W-1:0] line_addr_t; // addr[31:4]

    // ****************************************
    // channel payloads
    typedef struct packed {addr_t addr;} fetch_req_t;
    typedef struct packed {word_t rdata;} fetch_rsp_t;
    typedef struct packed {line_addr_t line_addr;} mem_req_t;
    typedef struct packed {line_t line;} mem_rsp_t;

    // refill write into the store
    typedef struct packed {
        logic   way;
        index_t index;
        tag_t   tag;
        line_t  line;
    } store_wr_t;

    // one set, both ways, as read out of the store
    typedef struct packed {
        logic [1:0]  valid;
        tag_t [1:0]  tag;
        line_t [1:0] line;
    } store_rd_t;

    typedef enum logic [1:0] {LK_RUN, LK_MISS, LK_FILL} lookup_state_e;

endpackage

// ==== design/icache_store.sv ====
/*
  tag, valid and data arrays of both ways
  read data shows up one cycle after rd_en_i and is held until the next read
  flush wins over a write in the same cycle
*/
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_store (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  rd_en_i,
    input  icache_pkg::index_t    rd_index_i,
    output icache_pkg::store_rd_t rd_o,
    input  logic                  wr_en_i,
    input  icache_pkg::store_wr_t wr_i,
    input  logic                  flush_i
);

    localparam int SETS = 1 << `ICACHE_SETS_LOG2;

    // ****************************************
    // arrays
    logic [1:0][SETS-1:0] valid_q;            // [way][set]
    icache_pkg::tag_t     tag_mem  [2][SETS];
    icache_pkg::line_t    data_mem [2][SETS];

    // valid bits are the only state that must come up clean
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;                    // all sets, both ways
        end else if (wr_en_i) begin
            valid_q[wr_i.way][wr_i.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_mem[wr_i.way][wr_i.index]  <= wr_i.tag;
            data_mem[wr_i.way][wr_i.index] <= wr_i.line;
        end
    end

    // ****************************************
    // registered read of one set
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            for (int w = 0; w < 2; w++) begin
                rd_o.valid[w] <= valid_q[w][rd_index_i];
                rd_o.tag[w]   <= tag_mem[w][rd_index_i];
                rd_o.line[w]  <= data_mem[w][rd_index_i];
            end
        end
    end

endmodule

// ==== design/icache_lookup.sv ====
/*
  request side of the cache: set read, tag compare, word select, miss handling
  holds one response; a new request is taken only when that slot frees up
  one round-robin pointer per set, flipped on every refill of that set
*/
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_lookup (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,
    input  logic                   fetch_req_valid_i,
    output logic                   fetch_req_ready_o,
    input  icache_pkg::fetch_req_t fetch_req_i,
    output logic                   fetch_rsp_valid_o,
    input  logic                   fetch_rsp_ready_i,
    output icache_pkg::fetch_rsp_t fetch_rsp_o,
    output logic                   store_rd_en_o,
    output icache_pkg::index_t     store_rd_index_o,
    input  icache_pkg::store_rd_t  store_rd_i,
    output logic                   store_wr_en_o,
    output icache_pkg::store_wr_t  store_wr_o,
    output logic                   store_flush_o,
    output logic                   refill_valid_o,
    output icache_pkg::line_addr_t refill_addr_o,
    input  logic                   refill_done_i,
    input  icache_pkg::line_t      refill_line_i
);

    localparam int SETS = 1 << `ICACHE_SETS_LOG2;

    function automatic icache_pkg::word_t word_sel(
        input icache_pkg::line_t             line,
        input logic [`ICACHE_WORDS_LOG2-1:0] off
    );
        return line[off*`ICACHE_WORD_W +: `ICACHE_WORD_W];
    endfunction

    icache_pkg::lookup_state_e     state_q;
    logic                          req_pend_q;  // read issued, decision pending
    logic                          rsp_valid_q;
    icache_pkg::fetch_rsp_t        rsp_q;
    logic [SETS-1:0]               ptr_q;       // victim way per set
    icache_pkg::tag_t              req_tag, tag_q;
    icache_pkg::index_t            req_idx, idx_q;
    logic [`ICACHE_WORDS_LOG2-1:0] req_word, word_q;
    logic [1:0]                    way_hit;
    logic                          hit, slot_free, decide, req_fire, rsp_fire;

    assign {req_tag, req_idx, req_word} = fetch_req_i.addr[`ICACHE_ADDR_W-1:`ICACHE_BYTE_OFF_W];

    // ****************************************
    // hit detection against the registered address
    for (genvar w = 0; w < 2; w++) begin : g_cmp
        assign way_hit[w] = store_rd_i.valid[w] && (store_rd_i.tag[w] == tag_q);
    end
    assign hit = |way_hit;

    assign slot_free = !rsp_valid_q || fetch_rsp_ready_i; // held rsp gone or leaving
    assign decide    = (state_q == icache_pkg::LK_RUN) && req_pend_q && slot_free;
    assign rsp_fire  = rsp_valid_q && fetch_rsp_ready_i;
    assign req_fire  = fetch_req_valid_i && fetch_req_ready_o;

    // a pending miss blocks the next request
    assign fetch_req_ready_o = (state_q == icache_pkg::LK_RUN) && slot_free
                             && !(req_pend_q && !hit) && !flush_i;

    assign store_rd_en_o    = req_fire;
    assign store_rd_index_o = req_idx;
    assign store_flush_o    = flush_i;
    assign refill_valid_o   = decide && !hit;  // single-cycle pulse
    assign refill_addr_o    = {tag_q, idx_q};

    assign store_wr_en_o    = (state_q == icache_pkg::LK_FILL);
    assign store_wr_o.way   = ptr_q[idx_q];
    assign store_wr_o.index = idx_q;
    assign store_wr_o.tag   = tag_q;
    assign store_wr_o.line  = refill_line_i;

    assign fetch_rsp_valid_o = rsp_valid_q;
    assign fetch_rsp_o       = rsp_q;

    // ****************************************
    // control
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q     <= icache_pkg::LK_RUN;
            req_pend_q  <= 1'b0;
            rsp_valid_q <= 1'b0;
            ptr_q       <= '0;
        end else begin
            if (rsp_fire) rsp_valid_q <= 1'b0;
            unique case (state_q)
                icache_pkg::LK_RUN: begin
                    if (decide) req_pend_q <= 1'b0;
                    if (req_fire) req_pend_q <= 1'b1;      // overlaps a resolving hit
                    if (decide && hit) rsp_valid_q <= 1'b1;
                    if (decide && !hit) state_q <= icache_pkg::LK_MISS;
                end
                icache_pkg::LK_MISS: begin
                    if (refill_done_i) state_q <= icache_pkg::LK_FILL;
                end
                icache_pkg::LK_FILL: begin
                    rsp_valid_q  <= 1'b1;
                    ptr_q[idx_q] <= ~ptr_q[idx_q];         // other way next time
                    state_q      <= icache_pkg::LK_RUN;
                end
                default: state_q <= icache_pkg::LK_RUN;
            endcase
        end
    end

    // address and response payload
    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            tag_q  <= req_tag;
            idx_q  <= req_idx;
            word_q <= req_word;
        end
        if (decide && hit) begin
            rsp_q.rdata <= word_sel(way_hit[1] ? store_rd_i.line[1] : store_rd_i.line[0], word_q);
        end else if (state_q == icache_pkg::LK_FILL) begin
            rsp_q.rdata <= word_sel(refill_line_i, word_q);
        end
    end

endmodule

// ==== design/icache_refill.sv ====
/*
  memory side: one line request per refill, then wait for the line
  the response is never accepted while the request is still pending
*/
`timescale 1ns/1ps

module icache_refill (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   refill_valid_i,
    input  icache_pkg::line_addr_t refill_addr_i,
    output logic                   refill_done_o,
    output icache_pkg::line_t      refill_line_o,
    output logic                   mem_req_valid_o,
    input  logic                   mem_req_ready_i,
    output icache_pkg::mem_req_t   mem_req_o,
    input  logic                   mem_rsp_valid_i,
    output logic                   mem_rsp_ready_o,
    input  icache_pkg::mem_rsp_t   mem_rsp_i
);

    typedef enum logic {RF_IDLE, RF_WAIT} refill_state_e;

    refill_state_e          state_q;
    logic                   req_valid_q;  // request still waiting for ready
    logic                   done_q;
    icache_pkg::line_addr_t addr_q;
    icache_pkg::line_t      line_q;
    logic                   rsp_fire;

    assign mem_rsp_ready_o = (state_q == RF_WAIT) && !req_valid_q;
    assign rsp_fire        = mem_rsp_valid_i && mem_rsp_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q     <= RF_IDLE;
            req_valid_q <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            done_q <= rsp_fire;                        // one-cycle pulse
            if (state_q == RF_IDLE && refill_valid_i) begin
                state_q     <= RF_WAIT;
                req_valid_q <= 1'b1;
            end
            if (req_valid_q && mem_req_ready_i) req_valid_q <= 1'b0;
            if (rsp_fire) state_q <= RF_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == RF_IDLE && refill_valid_i) addr_q <= refill_addr_i;
        if (rsp_fire) line_q <= mem_rsp_i.line;        // held until the next refill
    end

    assign mem_req_valid_o     = req_valid_q;
    assign mem_req_o.line_addr = addr_q;
    assign refill_done_o       = done_q;
    assign refill_line_o       = line_q;

endmodule

// ==== design/icache_top.sv ====
/*
  2-way set-associative instruction cache, 16 sets of 4-word lines
  read only; fetch addresses must be word aligned
*/
`timescale 1ns/1ps

module icache_top (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,
    input  logic                   fetch_req_valid_i,
    output logic                   fetch_req_ready_o,
    input  icache_pkg::fetch_req_t fetch_req_i,
    output logic                   fetch_rsp_valid_o,
    input  logic                   fetch_rsp_ready_i,
    output icache_pkg::fetch_rsp_t fetch_rsp_o,
    output logic                   mem_req_valid_o,
    input  logic                   mem_req_ready_i,
    output icache_pkg::mem_req_t   mem_req_o,
    input  logic                   mem_rsp_valid_i,
    output logic                   mem_rsp_ready_o,
    input  icache_pkg::mem_rsp_t   mem_rsp_i
);

    // lookup <-> store
    logic                   store_rd_en, store_wr_en, store_flush;
    icache_pkg::index_t     store_rd_index;
    icache_pkg::store_rd_t  store_rd;
    icache_pkg::store_wr_t  store_wr;
    // lookup <-> refill
    logic                   refill_valid, refill_done;
    icache_pkg::line_addr_t refill_addr;
    icache_pkg::line_t      refill_line;

    icache_lookup u_lookup (
        .clk_i, .rstn_i, .flush_i,
        .fetch_req_valid_i, .fetch_req_ready_o, .fetch_req_i,
        .fetch_rsp_valid_o, .fetch_rsp_ready_i, .fetch_rsp_o,
        .store_rd_en_o(store_rd_en), .store_rd_index_o(store_rd_index),
        .store_rd_i(store_rd), .store_wr_en_o(store_wr_en), .store_wr_o(store_wr),
        .store_flush_o(store_flush), .refill_valid_o(refill_valid),
        .refill_addr_o(refill_addr), .refill_done_i(refill_done),
        .refill_line_i(refill_line)
    );

    icache_store u_store (
        .clk_i, .rstn_i, .rd_en_i(store_rd_en), .rd_index_i(store_rd_index),
        .rd_o(store_rd), .wr_en_i(store_wr_en), .wr_i(store_wr), .flush_i(store_flush)
    );

    icache_refill u_refill (
        .clk_i, .rstn_i, .refill_valid_i(refill_valid), .refill_addr_i(refill_addr),
        .refill_done_o(refill_done), .refill_line_o(refill_line),
        .mem_req_valid_o, .mem_req_ready_i, .mem_req_o,
        .mem_rsp_valid_i, .mem_rsp_ready_o, .mem_rsp_i
    );

endmodule

// ==== bench/icache_properties.sv ====
/*
  handshake rules of icache_top
  bound into every instance and off while rstn_i is low
*/
`timescale 1ns/1ps

module icache_properties (
    input logic                   clk_i,
    input logic                   rstn_i,
    input logic                   fetch_req_valid_i,
    input logic                   fetch_req_ready_o,
    input logic                   fetch_rsp_valid_o,
    input logic                   fetch_rsp_ready_i,
    input icache_pkg::fetch_rsp_t fetch_rsp_o,
    input logic                   mem_req_valid_o,
    input logic                   mem_req_ready_i,
    input icache_pkg::mem_req_t   mem_req_o,
    input logic                   mem_rsp_ready_o
);

    logic req_seen_q;  // some fetch accepted since reset

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            req_seen_q <= 1'b0;
        end else if (fetch_req_valid_i && fetch_req_ready_o) begin
            req_seen_q <= 1'b1;
        end
    end

    // ****************************************
    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        fetch_rsp_valid_o && !fetch_rsp_ready_i |=> fetch_rsp_valid_o && $stable(fetch_rsp_o))
        else $error("fetch response dropped or changed before its handshake");

    a_mem_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
        else $error("memory request dropped or changed before its handshake");

    a_no_early_rsp: assert property (@(posedge clk_i) disable iff (!rstn_i)
        fetch_rsp_valid_o |-> req_seen_q)
        else $error("fetch response without an accepted request");

    // the edge that raises the request must not be one where a response could transfer
    a_req_rise: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(mem_req_valid_o) |-> !$past(mem_rsp_ready_o))
        else $error("memory request raised while response ready is high");

endmodule

bind icache_top icache_properties u_props (.*);

// ==== bench/icache_tb.sv ====
/*
  directed tests of icache_top against a line memory model
  memory word at byte address a is a ^ 32'hA5A5_0000
*/
`timescale 1ns/1ps

module icache_tb;

    logic                   clk_i = 1'b0;
    logic                   rstn_i, flush_i;
    logic                   fetch_req_valid_i, fetch_req_ready_o;
    icache_pkg::fetch_req_t fetch_req_i;
    logic                   fetch_rsp_valid_o, fetch_rsp_ready_i;
    icache_pkg::fetch_rsp_t fetch_rsp_o;
    logic                   mem_req_valid_o, mem_req_ready_i;
    icache_pkg::mem_req_t   mem_req_o;
    logic                   mem_rsp_valid_i, mem_rsp_ready_o;
    icache_pkg::mem_rsp_t   mem_rsp_i;

    int          errors = 0;
    int          cycles = 0;
    int          req_count = 0;     // memory requests taken by the model
    logic [27:0] last_line;
    int          m_st, m_wait;
    logic [31:0] m_rng = 32'h353d7cef;
    logic [31:0] s_rng = 32'h353d7cef;
    // reference model of tags, valid bits and victim pointers
    logic        ref_valid [16][2];
    logic [23:0] ref_tag   [16][2];
    logic        ref_ptr   [16];
    int          miss_count = 0;

    icache_top u_dut (.*);

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [127:0] line_of(input logic [27:0] la);
        logic [127:0] l;
        for (int k = 0; k < 4; k++)
            l[k*32 +: 32] = {la, 2'(k), 2'b00} ^ 32'hA5A5_0000;
        return l;
    endfunction

    // updates the model and returns the predicted hit
    function automatic logic predict_hit(input logic [31:0] a);
        int idx;
        logic w;
        idx = int'(a[7:4]);
        for (int k = 0; k < 2; k++)
            if (ref_valid[idx][k] && ref_tag[idx][k] == a[31:8]) return 1'b1;
        w = ref_ptr[idx];
        ref_valid[idx][w] = 1'b1;
        ref_tag[idx][w]   = a[31:8];
        ref_ptr[idx]      = ~w;
        miss_count++;
        return 1'b0;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns %s: expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // ****************************************
    // memory model with random accept and response delays of 0 to 3 cycles
    always @(posedge clk_i) begin
        if (!rstn_i) begin
            m_st <= 0;
            m_wait <= 0;
        end else begin
            m_rng <= xorshift(m_rng);
            case (m_st)
                0: if (mem_req_valid_o) begin
                    if (m_wait == 0) begin
                        mem_req_ready_i <= 1'b1;
                        m_st <= 1;
                    end else m_wait <= m_wait - 1;
                end
                1: begin                              // transfer on this edge
                    mem_req_ready_i <= 1'b0;
                    req_count <= req_count + 1;
                    last_line <= mem_req_o.line_addr;
                    m_wait <= int'(m_rng[1:0]);
                    m_st <= 2;
                end
                2: if (m_wait == 0) begin
                    mem_rsp_valid_i <= 1'b1;
                    mem_rsp_i.line <= line_of(last_line);
                    m_st <= 3;
                end else m_wait <= m_wait - 1;
                default: if (mem_rsp_ready_o) begin
                    mem_rsp_valid_i <= 1'b0;
                    m_wait <= int'(m_rng[3:2]);
                    m_st <= 0;
                end
            endcase
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= 4000) begin
            $display("timeout: tests did not finish within 4000 cycles");
            $display("TB FAILED");
            $finish;
        end
    end

    // one fetch; stall is the number of cycles the response is refused
    task automatic fetch_word(input logic [31:0] a, input int stall);
        logic        exp_hit;
        int          rc0, n, held;
        logic        seen;
        logic [31:0] first;
        exp_hit = predict_hit(a);
        rc0 = req_count;
        n = 0;
        held = 0;
        seen = 1'b0;
        first = '0;
        @(posedge clk_i);
        fetch_req_valid_i <= 1'b1;
        fetch_req_i.addr  <= a;
        fetch_rsp_ready_i <= (stall == 0);
        do @(posedge clk_i); while (!fetch_req_ready_o);
        fetch_req_valid_i <= 1'b0;
        forever begin
            @(posedge clk_i);
            n++;
            if (fetch_rsp_valid_o) begin
                if (seen) check("fetch_rsp_o held", first, fetch_rsp_o.rdata);
                if (fetch_rsp_ready_i) break;
                first = fetch_rsp_o.rdata;
                seen = 1'b1;
                check("fetch_req_ready_o", 32'd0, 32'(fetch_req_ready_o));
                held++;
                if (held >= stall) fetch_rsp_ready_i <= 1'b1;
            end
        end
        check("fetch_rsp_o.rdata", a ^ 32'hA5A5_0000, fetch_rsp_o.rdata);
        check("hit", 32'(exp_hit), 32'(req_count == rc0));
        if (exp_hit && stall == 0) check("hit latency", 32'd2, 32'(n));  // valid one edge on
        if (!exp_hit) check("mem_req_o.line_addr", 32'(a[31:4]), 32'(last_line));
    endtask

    task automatic flush_cache();
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        check("fetch_req_ready_o in flush", 32'd0, 32'(fetch_req_ready_o));
        flush_i <= 1'b0;
        for (int s = 0; s < 16; s++) begin
            ref_valid[s][0] = 1'b0;
            ref_valid[s][1] = 1'b0;
        end
    endtask

    // ****************************************
    task automatic cold_line_fetches();
        fetch_word(32'h0000_4010, 0);
        check("requests after cold fetch", 32'd1, 32'(req_count));
        fetch_word(32'h0000_4014, 0);
        fetch_word(32'h0000_4018, 0);
        fetch_word(32'h0000_401c, 0);
        check("requests after line hits", 32'd1, 32'(req_count));
    endtask

    task automatic conflict_replacement();
        fetch_word(32'h0001_0020, 0);      // A
        fetch_word(32'h0002_0020, 0);      // B
        fetch_word(32'h0003_0020, 0);      // C replaces A
        fetch_word(32'h0002_0024, 0);      // B still there
        fetch_word(32'h0001_0028, 0);      // A back in
        fetch_word(32'h0003_002c, 0);      // C kept, B was the victim
        check("requests after conflict", 32'(miss_count), 32'(req_count));
    endtask

    task automatic response_backpressure();
        fetch_word(32'h0000_4018, 5);
        fetch_word(32'h0000_5030, 4);      // miss under back-pressure
    endtask

    task automatic flush_and_refetch();
        flush_cache();
        fetch_word(32'h0002_0024, 0);
        fetch_word(32'h0001_0020, 0);
        fetch_word(32'h0002_002c, 0);
        check("requests after flush", 32'(miss_count), 32'(req_count));
    endtask

    task automatic random_stream();
        logic [31:0] a;
        for (int i = 0; i < 120; i++) begin
            s_rng = xorshift(s_rng);
            a = {24'h000100 | 24'(s_rng[1:0]), 4'(s_rng[15:8] % 6), s_rng[17:16], 2'b00};
            fetch_word(a, int'(s_rng[25:24]));
        end
        check("memory requests vs model misses", 32'(miss_count), 32'(req_count));
    endtask

    initial begin
        rstn_i = 1'b0;
        flush_i = 1'b0;
        fetch_req_valid_i = 1'b0;
        fetch_req_i = '0;
        fetch_rsp_ready_i = 1'b1;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_i = '0;
        for (int s = 0; s < 16; s++) begin
            ref_valid[s][0] = 1'b0;
            ref_valid[s][1] = 1'b0;
            ref_ptr[s] = 1'b0;
        end
        repeat (3) @(posedge clk_i);
        rstn_i <= 1'b1;
        cold_line_fetches();
        conflict_replacement();
        response_backpressure();
        flush_and_refetch();
        random_stream();
        repeat (2) @(posedge clk_i);
        $display("errors: %0d, memory requests: %0d, cycles: %0d", errors, req_count, cycles);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== icache_top.f ====
+incdir+design
design/icache_pkg.sv
design/icache_store.sv
design/icache_lookup.sv
design/icache_refill.sv
design/icache_top.sv
bench/icache_properties.sv
bench/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the cache testbench with Verilator and runs it
# exit status is 0 only when the simulation log holds the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module icache_tb \
    -f icache_top.f \
    --Mdir obj_dir -o icache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    cat build.log
    exit 1
fi

./obj_dir/icache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
